//--- include/forward_gen_config.svh
// Forward generator config: widths, FIFO sizing and credit limits

`ifndef FORWARD_GEN_CONFIG_SVH
`define FORWARD_GEN_CONFIG_SVH

// Packet field widths
`define FG_DATA_W   32
`define FG_HOPS_W   4
`define FG_DEST_W   4
`define FG_SEQ_W    8

// Run length counter
`define FG_COUNT_W  16

// FIFO sizing, threshold keeps four slots for control lag
`define FG_FIFO_DEPTH     16
`define FG_PROG_THRESH    12

// Downstream credits granted after reset
`define FG_EGRESS_CREDITS 4

`endif

//--- src/packet_pkg.sv
// Packet package: route header, engine packet and packet beat types

`include "forward_gen_config.svh"

package packet_pkg;

    // Routing header, 16 bits
    typedef struct packed {
        logic [`FG_DEST_W-1:0] dest;
        logic [`FG_SEQ_W-1:0]  seq_id;
        logic [`FG_HOPS_W-1:0] hops;
    } route_t;

    // Header then payload word, 48 bits
    typedef struct packed {
        route_t                route;
        logic [`FG_DATA_W-1:0] data;
    } engine_packet_t;

    // Packet on a wire with its valid qualifier
    typedef struct packed {
        logic           valid;
        engine_packet_t packet;
    } packet_beat_t;

endpackage : packet_pkg

//--- src/control_pkg.sv
// Control package: run descriptor and run state encoding

`include "forward_gen_config.svh"

package control_pkg;

    // One run consumes num_packets ingress packets
    typedef struct packed {
        logic                   valid;
        logic [`FG_COUNT_W-1:0] num_packets;
    } run_desc_t;

    typedef enum logic [1:0] {
        IDLE  = 2'd0,
        BUSY  = 2'd1,
        PAUSE = 2'd2,
        DONE  = 2'd3
    } run_state_t;

endpackage : control_pkg

//--- src/sync_fifo.sv
// Synchronous first-word-fall-through FIFO with programmable full flag

`include "forward_gen_config.svh"

module sync_fifo #(
    parameter int DEPTH = 16,
    parameter int WIDTH = 48
) (
    input  logic             ap_clk,
    input  logic             areset_generator,
    input  logic             push,
    input  logic [WIDTH-1:0] push_data,
    input  logic             pop,
    output logic [WIDTH-1:0] pop_data,
    output logic             empty,
    output logic             full,
    output logic             prog_full
);

    localparam int ADDR_W  = $clog2(DEPTH);
    localparam int COUNT_W = $clog2(DEPTH + 1);

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [ADDR_W-1:0]  wr_ptr;
    logic [ADDR_W-1:0]  rd_ptr;
    logic [COUNT_W-1:0] count;

    // ----------------------------------------
    // Storage and pointers
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (push) begin
            mem[wr_ptr] <= push_data;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == ADDR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (pop) begin
                rd_ptr <= (rd_ptr == ADDR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
        end
    end

    // Head word is presented while not empty
    assign pop_data  = mem[rd_ptr];
    assign empty     = (count == '0);
    assign full      = (count == COUNT_W'(DEPTH));
    assign prog_full = (count >= COUNT_W'(`FG_PROG_THRESH));

    // Upstream credit accounting must keep these from firing
    assert property (@(posedge ap_clk) disable iff (areset_generator) push |-> !full);
    assert property (@(posedge ap_clk) disable iff (areset_generator) pop |-> !empty);

endmodule : sync_fifo

//--- src/hop_forwarder.sv
// Hop forwarder: pops ingress packets, decrements hops, drops expired ones

module hop_forwarder (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  logic                       run_enable,
    input  packet_pkg::engine_packet_t in_packet,
    input  logic                       in_empty,
    output logic                       pop,
    output logic                       out_push,
    output packet_pkg::engine_packet_t out_packet,
    output logic                       in_flight
);

    packet_pkg::engine_packet_t next_packet;
    logic                       hops_left;

    // One pop per cycle while the run is enabled
    assign pop = run_enable && !in_empty;

    // Zero hops means the packet has expired
    assign hops_left = (in_packet.route.hops != '0);

    always_comb begin
        next_packet            = in_packet;
        next_packet.route.hops = in_packet.route.hops - 1'b1;
    end

    // ----------------------------------------
    // Output register
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            out_push <= 1'b0;
        end else begin
            out_push <= pop && hops_left;
        end
    end

    always_ff @(posedge ap_clk) begin
        if (pop) begin
            out_packet <= next_packet;
        end
    end

    // A packet being popped or one held in the register
    assign in_flight = pop || out_push;

endmodule : hop_forwarder

//--- src/forward_gen_control.sv
// Run control block with descriptor capture, run FSM, consumed count, pause and done

`include "forward_gen_config.svh"

module forward_gen_control (
    input  logic                   ap_clk,
    input  logic                   areset_generator,
    input  control_pkg::run_desc_t run_desc,
    input  logic                   pop,
    input  logic                   in_flight,
    input  logic                   egress_prog_full,
    input  logic                   egress_empty,
    output logic                   run_enable,
    output logic                   busy,
    output logic                   done
);

    control_pkg::run_state_t state;
    control_pkg::run_state_t next_state;
    control_pkg::run_desc_t  desc_q;
    logic [`FG_COUNT_W-1:0]  consumed;
    logic                    run_start;
    logic                    all_consumed;
    logic                    drained;

    assign run_start    = (state == control_pkg::IDLE) && run_desc.valid;
    assign all_consumed = (consumed == desc_q.num_packets);
    assign drained      = all_consumed && !in_flight && egress_empty;

    // ----------------------------------------
    // Descriptor and consumed counter
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            desc_q   <= '0;
            consumed <= '0;
        end else if (run_start) begin
            desc_q   <= run_desc;
            consumed <= '0;
        end else if (pop) begin
            consumed <= consumed + 1'b1;
        end
    end

    // ----------------------------------------
    // Run state machine
    // ----------------------------------------
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            state <= control_pkg::IDLE;
        end else begin
            state <= next_state;
        end
    end

    always_comb begin
        next_state = state;
        case (state)
            control_pkg::IDLE: begin
                if (run_desc.valid) begin
                    next_state = control_pkg::BUSY;
                end
            end
            control_pkg::BUSY: begin
                if (drained) begin
                    next_state = control_pkg::DONE;
                end else if (egress_prog_full) begin
                    next_state = control_pkg::PAUSE;
                end
            end
            control_pkg::PAUSE: begin
                if (!egress_prog_full) begin
                    next_state = control_pkg::BUSY;
                end
            end
            control_pkg::DONE: begin
                next_state = control_pkg::IDLE;
            end
            default: begin
                next_state = control_pkg::IDLE;
            end
        endcase
    end

    // Stop popping once the run length is reached
    assign run_enable = (state == control_pkg::BUSY) && !all_consumed;
    assign busy       = (state == control_pkg::BUSY) || (state == control_pkg::PAUSE);
    assign done       = (state == control_pkg::DONE);

    // Nothing popped, registered or queued while done pulses
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        (state == control_pkg::DONE) |-> (all_consumed && !in_flight && egress_empty));

endmodule : forward_gen_control

//--- src/credit_egress.sv
// Credit egress: spends downstream credits to drain the egress FIFO

`include "forward_gen_config.svh"

module credit_egress (
    input  logic                       ap_clk,
    input  logic                       areset_generator,
    input  packet_pkg::engine_packet_t fifo_packet,
    input  logic                       fifo_empty,
    input  logic                       egress_credit,
    output logic                       fifo_pop,
    output packet_pkg::packet_beat_t   egress_beat
);

    localparam int CREDIT_W = $clog2(`FG_EGRESS_CREDITS + 1);

    logic [CREDIT_W-1:0] credit_count;

    assign fifo_pop = (credit_count != '0) && !fifo_empty;

    // Send and return in one cycle cancel out
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            credit_count <= CREDIT_W'(`FG_EGRESS_CREDITS);
        end else if (fifo_pop && !egress_credit) begin
            credit_count <= credit_count - 1'b1;
        end else if (egress_credit && !fifo_pop) begin
            credit_count <= credit_count + 1'b1;
        end
    end

    // Registered output beat
    always_ff @(posedge ap_clk) begin
        if (areset_generator) begin
            egress_beat.valid <= 1'b0;
        end else begin
            egress_beat.valid <= fifo_pop;
        end
    end

    always_ff @(posedge ap_clk) begin
        egress_beat.packet <= fifo_packet;
    end

    // Downstream never returns more than it was granted
    assert property (@(posedge ap_clk) disable iff (areset_generator)
        credit_count <= CREDIT_W'(`FG_EGRESS_CREDITS));

endmodule : credit_egress

//--- src/forward_gen_top.sv
// Forward generator top: ingress FIFO, hop forwarder, egress FIFO and control

`include "forward_gen_config.svh"

module forward_gen_top (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  control_pkg::run_desc_t   run_desc,
    input  packet_pkg::packet_beat_t ingress_beat,
    input  logic                     egress_credit,
    output logic                     ingress_credit,
    output packet_pkg::packet_beat_t egress_beat,
    output logic                     busy,
    output logic                     done
);

    localparam int PKT_W = $bits(packet_pkg::engine_packet_t);

    packet_pkg::engine_packet_t ingress_head;
    packet_pkg::engine_packet_t fwd_packet;
    packet_pkg::engine_packet_t egress_head;
    logic                       ingress_empty;
    logic                       fwd_pop;
    logic                       fwd_push;
    logic                       fwd_in_flight;
    logic                       run_enable;
    logic                       egress_pop;
    logic                       egress_empty;
    logic                       egress_prog_full;

    // Each pop frees one ingress slot
    assign ingress_credit = fwd_pop;

    // ----------------------------------------
    // Ingress side
    // ----------------------------------------
    sync_fifo #(
        .DEPTH(`FG_FIFO_DEPTH),
        .WIDTH(PKT_W)
    ) ingress_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (ingress_beat.valid),
        .push_data        (ingress_beat.packet),
        .pop              (fwd_pop),
        .pop_data         (ingress_head),
        .empty            (ingress_empty),
        .full             (),
        .prog_full        ()
    );

    hop_forwarder hop_forwarder_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run_enable       (run_enable),
        .in_packet        (ingress_head),
        .in_empty         (ingress_empty),
        .pop              (fwd_pop),
        .out_push         (fwd_push),
        .out_packet       (fwd_packet),
        .in_flight        (fwd_in_flight)
    );

    // ----------------------------------------
    // Egress side
    // ----------------------------------------
    sync_fifo #(
        .DEPTH(`FG_FIFO_DEPTH),
        .WIDTH(PKT_W)
    ) egress_fifo_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .push             (fwd_push),
        .push_data        (fwd_packet),
        .pop              (egress_pop),
        .pop_data         (egress_head),
        .empty            (egress_empty),
        .full             (),
        .prog_full        (egress_prog_full)
    );

    credit_egress credit_egress_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .fifo_packet      (egress_head),
        .fifo_empty       (egress_empty),
        .egress_credit    (egress_credit),
        .fifo_pop         (egress_pop),
        .egress_beat      (egress_beat)
    );

    forward_gen_control forward_gen_control_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run_desc         (run_desc),
        .pop              (fwd_pop),
        .in_flight        (fwd_in_flight),
        .egress_prog_full (egress_prog_full),
        .egress_empty     (egress_empty),
        .run_enable       (run_enable),
        .busy             (busy),
        .done             (done)
    );

endmodule : forward_gen_top

//--- verification/forward_gen_checker.sv
// Forward generator checker comparing egress beats with a reference model

`include "forward_gen_config.svh"

module forward_gen_checker (
    input  logic                     ap_clk,
    input  logic                     areset_generator,
    input  int                       run_id,
    input  control_pkg::run_desc_t   run_desc,
    input  packet_pkg::packet_beat_t ingress_beat,
    input  logic                     ingress_credit,
    input  packet_pkg::packet_beat_t egress_beat,
    input  logic                     egress_credit,
    input  logic                     busy,
    input  logic                     done,
    output int                       error_count,
    output int                       done_count
);

    packet_pkg::engine_packet_t expected_q[$];
    packet_pkg::engine_packet_t exp_pkt;
    packet_pkg::packet_beat_t   ref_beat;
    int   errors = 0;
    int   dones = 0;
    int   sent_count = 0;
    int   dropped_count = 0;
    int   beat_count = 0;
    int   credit_pulses = 0;
    int   outstanding = 0;
    logic desc_seen = 1'b0;
    logic done_seen = 1'b0;
    logic run_active = 1'b0;

    assign error_count = errors;
    assign done_count  = dones;

    // Expected egress beat for one ingress packet
    // Valid is low for a dropped packet
    function automatic packet_pkg::packet_beat_t forward_ref(
        input packet_pkg::engine_packet_t pkt
    );
        packet_pkg::packet_beat_t beat;
        beat.packet = pkt;
        beat.valid  = (pkt.route.hops != '0);
        if (beat.valid) begin
            beat.packet.route.hops = pkt.route.hops - 1'b1;
        end
        return beat;
    endfunction

    always @(negedge ap_clk) begin
        if (areset_generator) begin
            if (busy || done || egress_beat.valid || ingress_credit) begin
                $display("ERROR: outputs not idle during reset at time %0t", $time);
                errors++;
            end
        end else begin
            // ----------------------------------------
            // Ingress side
            // ----------------------------------------
            if (ingress_beat.valid) begin
                ref_beat = forward_ref(ingress_beat.packet);
                sent_count++;
                if (ref_beat.valid) begin
                    expected_q.push_back(ref_beat.packet);
                end else begin
                    dropped_count++;
                end
            end
            if (ingress_credit) begin
                credit_pulses++;
            end

            // ----------------------------------------
            // Egress side
            // ----------------------------------------
            if (egress_beat.valid) begin
                beat_count++;
                outstanding++;
                if (expected_q.size() == 0) begin
                    $display("ERROR: run%0d sent an egress beat when none was expected",
                             run_id);
                    errors++;
                end else begin
                    exp_pkt = expected_q.pop_front();
                    if (egress_beat.packet !== exp_pkt) begin
                        $display("MISMATCH run%0d_forward: expected %h actual %h",
                                 run_id, exp_pkt, egress_beat.packet);
                        errors++;
                    end
                end
            end
            if (egress_credit) begin
                outstanding--;
            end
            if (outstanding > `FG_EGRESS_CREDITS) begin
                $display("ERROR: run%0d has %0d egress beats outstanding, more than credits",
                         run_id, outstanding);
                errors++;
            end

            // ----------------------------------------
            // Run control
            // ----------------------------------------
            if (desc_seen && !busy) begin
                $display("ERROR: run%0d busy not raised the cycle after the descriptor", run_id);
                errors++;
            end
            desc_seen = run_desc.valid && !busy && !done;
            if (desc_seen) begin
                run_active = 1'b1;
            end
            if (done_seen && (busy || done)) begin
                $display("ERROR: run%0d busy or done still high after the done pulse", run_id);
                errors++;
            end
            if (done) begin
                dones++;
                if (!run_active) begin
                    $display("ERROR: run%0d pulsed done with no run in progress", run_id);
                    errors++;
                end
                run_active = 1'b0;
                if (busy) begin
                    $display("ERROR: run%0d busy high together with done", run_id);
                    errors++;
                end
                if (expected_q.size() != 0) begin
                    $display("ERROR: run%0d done with %0d packets still expected",
                             run_id, expected_q.size());
                    errors++;
                end
                if (credit_pulses != sent_count) begin
                    $display("MISMATCH run%0d_credits: expected %0d actual %0d",
                             run_id, sent_count, credit_pulses);
                    errors++;
                end
                if (beat_count != sent_count - dropped_count) begin
                    $display("MISMATCH run%0d_beats: expected %0d actual %0d",
                             run_id, sent_count - dropped_count, beat_count);
                    errors++;
                end
            end
            done_seen = done;
        end
    end

endmodule : forward_gen_checker

//--- verification/forward_gen_tb.sv
// Forward generator testbench: LFSR stimulus, credit models, DUT and checker

`include "forward_gen_config.svh"

module forward_gen_tb;

    localparam int WAIT_LIMIT = 2000;
    // Downstream holds its credits after this many beats
    localparam int LONG_STALL_BEAT = 40;

    logic                     ap_clk;
    logic                     areset_generator;
    control_pkg::run_desc_t   run_desc;
    packet_pkg::packet_beat_t ingress_beat;
    logic                     egress_credit;
    logic                     ingress_credit;
    packet_pkg::packet_beat_t egress_beat;
    logic                     busy;
    logic                     done;

    logic [15:0] stim_lfsr;
    logic [15:0] credit_lfsr;
    int          run_id;
    int          packets_sent;
    int          credits_back = 0;
    int          timeouts;
    int          error_count;
    int          done_count;

    // Galois LFSR step, taps 16 14 13 11
    function automatic logic [15:0] lfsr_next(input logic [15:0] state);
        if (state[0]) begin
            return (state >> 1) ^ 16'hB400;
        end
        return state >> 1;
    endfunction

    // One LFSR step per random bit taken
    function automatic logic [31:0] take_bits(inout logic [15:0] state, input int n);
        logic [31:0] value;
        value = '0;
        for (int i = 0; i < n; i++) begin
            value = {value[30:0], state[0]};
            state = lfsr_next(state);
        end
        return value;
    endfunction

    always #5 ap_clk = ~ap_clk;

    forward_gen_top forward_gen_top_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run_desc         (run_desc),
        .ingress_beat     (ingress_beat),
        .egress_credit    (egress_credit),
        .ingress_credit   (ingress_credit),
        .egress_beat      (egress_beat),
        .busy             (busy),
        .done             (done)
    );

    forward_gen_checker forward_gen_checker_i (
        .ap_clk           (ap_clk),
        .areset_generator (areset_generator),
        .run_id           (run_id),
        .run_desc         (run_desc),
        .ingress_beat     (ingress_beat),
        .ingress_credit   (ingress_credit),
        .egress_beat      (egress_beat),
        .egress_credit    (egress_credit),
        .busy             (busy),
        .done             (done),
        .error_count      (error_count),
        .done_count       (done_count)
    );

    // Ingress FIFO slots freed by the forwarder
    always @(negedge ap_clk) begin
        if (ingress_credit) begin
            credits_back++;
        end
    end

    // ----------------------------------------
    // Downstream credit model
    // ----------------------------------------
    initial begin : downstream_model
        int pending;
        int stall_cycles;
        int beats_seen;
        pending = 0;
        stall_cycles = 0;
        beats_seen = 0;
        egress_credit = 1'b0;
        credit_lfsr = 16'd18;
        forever begin
            @(posedge ap_clk);
            #1;
            egress_credit = 1'b0;
            if (egress_beat.valid) begin
                pending++;
                beats_seen++;
                if (beats_seen == LONG_STALL_BEAT) begin
                    stall_cycles = 150;
                end
            end
            if (stall_cycles > 0) begin
                stall_cycles--;
            end else if (pending > 0) begin
                egress_credit = 1'b1;
                pending--;
                if (take_bits(credit_lfsr, 3) == 32'd0) begin
                    stall_cycles = 30;
                end else begin
                    stall_cycles = int'(take_bits(credit_lfsr, 2));
                end
            end
        end
    end

    // Wait for an ingress credit, then drive one random packet
    task automatic send_packet();
        int                         waited;
        int                         gap;
        logic [31:0]                bits;
        packet_pkg::engine_packet_t pkt;
        waited = 0;
        while (packets_sent - credits_back >= `FG_FIFO_DEPTH && waited < WAIT_LIMIT) begin
            @(posedge ap_clk);
            #1;
            waited++;
        end
        if (packets_sent - credits_back >= `FG_FIFO_DEPTH) begin
            $display("TIMEOUT: no ingress credit came back within %0d cycles", WAIT_LIMIT);
            timeouts++;
        end else begin
            bits = take_bits(stim_lfsr, 4);
            pkt.route.dest = bits[`FG_DEST_W-1:0];
            pkt.route.seq_id = packets_sent[`FG_SEQ_W-1:0];
            // About one packet in four arrives already expired
            bits = (take_bits(stim_lfsr, 2) == 32'd0) ? 32'd0 : take_bits(stim_lfsr, 4);
            pkt.route.hops = bits[`FG_HOPS_W-1:0];
            pkt.data = take_bits(stim_lfsr, 32);
            ingress_beat.packet = pkt;
            ingress_beat.valid = 1'b1;
            packets_sent++;
            @(posedge ap_clk);
            #1;
            ingress_beat.valid = 1'b0;
            gap = int'(take_bits(stim_lfsr, 2));
            repeat (gap) begin
                @(posedge ap_clk);
                #1;
            end
        end
    endtask

    // Start a descriptor run, feed its packets, wait for done
    task automatic execute_run(input int id, input int num);
        int target;
        int waited;
        target = done_count + 1;
        run_id = id;
        run_desc.num_packets = num[`FG_COUNT_W-1:0];
        run_desc.valid = 1'b1;
        @(posedge ap_clk);
        #1;
        run_desc = '0;
        for (int i = 0; i < num; i++) begin
            send_packet();
        end
        waited = 0;
        while (done_count < target && waited < WAIT_LIMIT) begin
            @(posedge ap_clk);
            #1;
            waited++;
        end
        if (done_count < target) begin
            $display("TIMEOUT: run %0d did not signal done within %0d cycles", id, WAIT_LIMIT);
            timeouts++;
        end
        repeat (3) begin
            @(posedge ap_clk);
            #1;
        end
    endtask

    initial begin : main_flow
        ap_clk = 1'b0;
        areset_generator = 1'b1;
        run_desc = '0;
        ingress_beat = '0;
        stim_lfsr = 16'd18;
        run_id = 0;
        packets_sent = 0;
        timeouts = 0;
        repeat (4) @(posedge ap_clk);
        #1;
        areset_generator = 1'b0;
        repeat (2) @(posedge ap_clk);
        #1;
        // Second run hits the long downstream stall
        execute_run(1, 40);
        execute_run(2, 80);
        repeat (5) @(posedge ap_clk);
        $display("Summary: %0d check errors, %0d timeouts, %0d packets sent",
                 error_count, timeouts, packets_sent);
        if (error_count == 0 && timeouts == 0) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule : forward_gen_tb

//--- verilog.f
+incdir+include
src/packet_pkg.sv
src/control_pkg.sv
src/sync_fifo.sv
src/hop_forwarder.sv
src/forward_gen_control.sv
src/credit_egress.sv
src/forward_gen_top.sv
verification/forward_gen_checker.sv
verification/forward_gen_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build and run the forward generator testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert --top-module forward_gen_tb \
    -f verilog.f -o forward_gen_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/forward_gen_sim > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Result: FAILED" "$LOG"; then
    exit 1
fi
exit 0
